//--- compile.f
mvau_pkg.sv
mvau_weight_mem.sv
mvau_pe.sv
mvau_input_buf.sv
mvau_out_pack.sv
mvau_top.sv
tb_mvau.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MVAU testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mvau \
   -f compile.f -o sim_mvau \
   || { echo "build failed"; exit 1; }
./obj_dir/sim_mvau > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "result: failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "result: no verdict"; exit 1; }
echo "result: passed"

//--- tb_mvau.sv
/* MVAU testbench
   LFSR weights and vectors, reference dot products, assertion based checks */

`timescale 1ns/1ps
`default_nettype none

module tb_mvau;

   import mvau_pkg::*;

   localparam int SIMD     = DEF_SIMD;
   localparam int PE       = DEF_PE;
   localparam int TI       = DEF_TI;
   localparam int TW       = DEF_TW;
   localparam int TA       = DEF_TA;
   localparam int MATRIX_W = DEF_MATRIX_W;
   localparam int MATRIX_H = DEF_MATRIX_H;
   localparam int SF       = calc_sf(MATRIX_W, SIMD);
   localparam int NF       = calc_nf(MATRIX_H, PE);
   localparam int DEPTH    = SF * NF;
   localparam int ADDR_BW  = wmem_addr_bw(SF, NF);
   localparam int PE_BW    = idx_bw(PE);
   localparam int N_RAND   = 4;
   localparam int N_VEC    = 3 + N_RAND;
   // Reset, idle, all loads, every vector with its drain, per-test idle, margin
   localparam int MAX_CYC  = 16 + 20 + (2 * PE + 1) * DEPTH
                             + N_VEC * (SF + NF * SF + 4) + 5 * 8 + 100;

   logic                clk        = 1'b0;
   logic                rst_n      = 1'b0;
   logic                in_valid   = 1'b0;
   logic [SIMD*TI-1:0]  in_data    = '0;
   logic                in_busy;
   logic                wload_en   = 1'b0;
   logic [PE_BW-1:0]    wload_pe   = '0;
   logic [ADDR_BW-1:0]  wload_addr = '0;
   logic [SIMD*TW-1:0]  wload_data = '0;
   logic [PE*TA-1:0]    out_data;
   logic                out_valid;

   // Reference state
   int                  wgt [MATRIX_H][MATRIX_W];
   int                  act [MATRIX_W];
   logic [PE*TA-1:0]    exp_q [$];
   logic [PE*TA-1:0]    exp_head  = '0;
   logic                exp_ok    = 1'b0;
   int                  out_cnt   = 0;
   int                  err_cnt   = 0;
   int                  test_err0 = 0;
   int                  test_cnt  = 0;
   int                  test_fail = 0;
   int                  cyc       = 0;
   logic [31:0]         lfsr      = 32'd99515;

   mvau_top #(
      .SIMD(SIMD), .PE(PE), .TI(TI), .TW(TW), .TA(TA),
      .MATRIX_W(MATRIX_W), .MATRIX_H(MATRIX_H)
   ) i_mvau_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_busy    (in_busy),
      .wload_en   (wload_en),
      .wload_pe   (wload_pe),
      .wload_addr (wload_addr),
      .wload_data (wload_data),
      .out_data   (out_data),
      .out_valid  (out_valid)
   );

   initial begin
      forever #20 clk = ~clk;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Two's complement field of n bits to int
   function automatic int sext(input logic [31:0] r, input int n);
      int t;
      t = int'(r << (32 - n));
      return t >>> (32 - n);
   endfunction

   // Rows owned by lane p are p, p+PE, ...
   task automatic rand_weights(input int p);
      for (int r = p; r < MATRIX_H; r += PE) begin
         for (int c = 0; c < MATRIX_W; c++) begin
            wgt[r][c] = sext(rand_bits(TW), TW);
         end
      end
   endtask

   task automatic rand_vector();
      for (int c = 0; c < MATRIX_W; c++) begin
         act[c] = sext(rand_bits(TI), TI);
      end
   endtask

   // Dot products per fold, wrapped to TA bits
   task automatic push_expected();
      logic [PE*TA-1:0] word;
      int               sum;
      for (int nf = 0; nf < NF; nf++) begin
         for (int p = 0; p < PE; p++) begin
            sum = 0;
            for (int c = 0; c < MATRIX_W; c++) begin
               sum += wgt[nf*PE+p][c] * act[c];
            end
            word[p*TA +: TA] = sum[TA-1:0];
         end
         exp_q.push_back(word);
      end
   endtask

   // Address nf*SF+sf holds row nf*PE+p, columns sf*SIMD up
   task automatic load_lane(input int p);
      for (int nf = 0; nf < NF; nf++) begin
         for (int sf = 0; sf < SF; sf++) begin
            wload_en   = 1'b1;
            wload_pe   = PE_BW'(p);
            wload_addr = ADDR_BW'(nf * SF + sf);
            for (int s = 0; s < SIMD; s++) begin
               wload_data[s*TW +: TW] = TW'(wgt[nf*PE+p][sf*SIMD+s]);
            end
            @(negedge clk);
         end
      end
      wload_en = 1'b0;
   endtask

   // Starts as soon as the buffer is free
   task automatic send_vector();
      while (in_busy) @(negedge clk);
      for (int sf = 0; sf < SF; sf++) begin
         in_valid = 1'b1;
         for (int s = 0; s < SIMD; s++) begin
            in_data[s*TI +: TI] = TI'(act[sf*SIMD+s]);
         end
         @(negedge clk);
      end
      in_valid = 1'b0;
   endtask

   // Drain, idle a little, then count the pulses
   task automatic end_test(input string name);
      while (out_cnt < exp_q.size()) @(negedge clk);
      repeat (8) @(negedge clk);
      a_pulse_count : assert (out_cnt == exp_q.size()) else begin
         err_cnt++;
         $display("%0t: saw %0d output pulses, wanted %0d", $time, out_cnt, exp_q.size());
      end
      test_cnt++;
      if (err_cnt != test_err0) test_fail++;
      $display("test %0d %s: %s", test_cnt, name, (err_cnt == test_err0) ? "ok" : "errors");
      test_err0 = err_cnt;
   endtask

   // Output counter and queue head, updated on the rising edge
   always @(posedge clk) begin
      if (rst_n && out_valid) begin
         out_cnt = out_cnt + 1;
      end
      exp_ok = (out_cnt < exp_q.size());
      if (exp_ok) exp_head = exp_q[out_cnt];
   end

   // Outputs are compared mid-cycle
   a_out_match : assert property (
      @(negedge clk) disable iff (!rst_n)
      (out_valid && exp_ok) |-> (out_data == exp_head)
   ) else begin
      err_cnt++;
      $display("error: time %0t out_data expected %h actual %h", $time, exp_head, out_data);
   end

   a_no_spurious : assert property (
      @(negedge clk) disable iff (!rst_n)
      out_valid |-> exp_ok
   ) else begin
      err_cnt++;
      $display("%0t: output pulse with no result pending", $time);
   end

   a_reset_levels : assert property (
      @(negedge clk) !rst_n |-> (!out_valid && !in_busy)
   ) else begin
      err_cnt++;
      $display("%0t: out_valid or in_busy high during reset", $time);
   end

   initial begin : watchdog
      while (cyc < MAX_CYC) begin
         @(posedge clk);
         cyc++;
      end
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      int               corner;
      logic [PE*TA-1:0] word;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Idle DUT stays quiet
      repeat (20) @(negedge clk);
      a_idle_after_reset : assert (!in_busy && !out_valid && out_cnt == 0) else begin
         err_cnt++;
         $display("%0t: DUT not idle after reset", $time);
      end
      end_test("reset and idle");

      for (int p = 0; p < PE; p++) begin
         rand_weights(p);
         load_lane(p);
      end
      rand_vector();
      push_expected();
      send_vector();
      end_test("random weights, one vector");

      // Most negative operands, result from the closed form
      for (int r = 0; r < MATRIX_H; r++) begin
         for (int c = 0; c < MATRIX_W; c++) begin
            wgt[r][c] = -(1 << (TW - 1));
         end
      end
      for (int c = 0; c < MATRIX_W; c++) begin
         act[c] = -(1 << (TI - 1));
      end
      for (int p = 0; p < PE; p++) begin
         load_lane(p);
      end
      corner = MATRIX_W * (1 << (TI - 1)) * (1 << (TW - 1));
      word   = {PE{corner[TA-1:0]}};
      for (int nf = 0; nf < NF; nf++) begin
         exp_q.push_back(word);
      end
      send_vector();
      end_test("most negative operands");

      // Lane 1 only, same vector again
      rand_weights(1);
      load_lane(1);
      push_expected();
      send_vector();
      end_test("one lane rewritten");

      for (int v = 0; v < N_RAND; v++) begin
         rand_vector();
         push_expected();
         send_vector();
      end
      end_test("back to back vectors");

      $display("tests %0d, failed %0d, outputs %0d, errors %0d",
               test_cnt, test_fail, out_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mvau_top.sv
/* MVAU top level
   Input buffer feeding PE lanes, results gathered by the output packer */

`timescale 1ns/1ps
`default_nettype none

module mvau_top #(
   parameter int SIMD     = mvau_pkg::DEF_SIMD,
   parameter int PE       = mvau_pkg::DEF_PE,
   parameter int TI       = mvau_pkg::DEF_TI,
   parameter int TW       = mvau_pkg::DEF_TW,
   parameter int TA       = mvau_pkg::DEF_TA,
   parameter int MATRIX_W = mvau_pkg::DEF_MATRIX_W,
   parameter int MATRIX_H = mvau_pkg::DEF_MATRIX_H
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              in_valid,
   input  logic [SIMD*TI-1:0]                in_data,
   output logic                              in_busy,
   input  logic                              wload_en,
   input  logic [mvau_pkg::idx_bw(PE)-1:0]   wload_pe,
   input  logic [mvau_pkg::wmem_addr_bw(
                    mvau_pkg::calc_sf(MATRIX_W, SIMD),
                    mvau_pkg::calc_nf(MATRIX_H, PE))-1:0] wload_addr,
   input  logic [SIMD*TW-1:0]                wload_data,
   output logic [PE*TA-1:0]                  out_data,
   output logic                              out_valid
);

   import mvau_pkg::*;

   localparam int ADDR_BW = wmem_addr_bw(calc_sf(MATRIX_W, SIMD), calc_nf(MATRIX_H, PE));

   // Broadcast to all lanes
   logic [ADDR_BW-1:0]  wmem_addr;
   logic [SIMD*TI-1:0]  act_word;
   logic                acc_first;
   logic                acc_last;
   // Lane results
   logic [PE*TA-1:0]    acc_out;
   logic [PE-1:0]       acc_valid;

   mvau_input_buf #(
      .SIMD(SIMD), .TI(TI), .MATRIX_W(MATRIX_W), .MATRIX_H(MATRIX_H), .PE(PE)
   ) i_input_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_busy   (in_busy),
      .wmem_addr (wmem_addr),
      .act_word  (act_word),
      .acc_first (acc_first),
      .acc_last  (acc_last)
   );

   for (genvar p = 0; p < PE; p++) begin : g_pe
      mvau_pe #(
         .PE_ID(p), .SIMD(SIMD), .TI(TI), .TW(TW), .TA(TA),
         .MATRIX_W(MATRIX_W), .MATRIX_H(MATRIX_H), .PE(PE)
      ) i_pe (
         .clk        (clk),
         .rst_n      (rst_n),
         .wmem_addr  (wmem_addr),
         .act_word   (act_word),
         .acc_first  (acc_first),
         .acc_last   (acc_last),
         .wload_en   (wload_en),
         .wload_pe   (wload_pe),
         .wload_addr (wload_addr),
         .wload_data (wload_data),
         .acc_out    (acc_out[p*TA +: TA]),
         .acc_valid  (acc_valid[p])
      );
   end

   mvau_out_pack #(.PE(PE), .TA(TA)) i_out_pack (
      .clk       (clk),
      .rst_n     (rst_n),
      .acc_out   (acc_out),
      .acc_valid (acc_valid),
      .out_data  (out_data),
      .out_valid (out_valid)
   );

endmodule

`default_nettype wire

//--- mvau_out_pack.sv
/* MVAU output packer
   Registers the lane results of one neuron fold and pulses out_valid */

`timescale 1ns/1ps
`default_nettype none

module mvau_out_pack #(
   parameter int PE = 4,
   parameter int TA = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [PE*TA-1:0]  acc_out,
   input  logic [PE-1:0]     acc_valid,
   output logic [PE*TA-1:0]  out_data,
   output logic              out_valid
);

   logic fold_done;

   // All lanes finish a fold together
   assign fold_done = &acc_valid;

   // Result word, lane p at offset p*TA
   always_ff @(posedge clk) begin
      if (fold_done) begin
         out_data <= acc_out;
      end
   end

   // One pulse per fold
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= fold_done;
      end
   end

   // A lane out of step points at broken sequencing upstream
   a_lanes_in_step : assert property (
      @(posedge clk) disable iff (!rst_n)
      (|acc_valid) |-> (&acc_valid)
   ) else $error("lane valids out of step: %b", acc_valid);

endmodule

`default_nettype wire

//--- mvau_input_buf.sv
/* MVAU input buffer
   Collects one input vector, replays it per neuron fold with weight addresses */

`timescale 1ns/1ps
`default_nettype none

module mvau_input_buf #(
   parameter int SIMD     = 4,
   parameter int TI       = 4,
   parameter int MATRIX_W = 16,
   parameter int MATRIX_H = 8,
   parameter int PE       = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   input  logic [SIMD*TI-1:0]  in_data,
   output logic                in_busy,
   output logic [mvau_pkg::wmem_addr_bw(
                    mvau_pkg::calc_sf(MATRIX_W, SIMD),
                    mvau_pkg::calc_nf(MATRIX_H, PE))-1:0] wmem_addr,
   output logic [SIMD*TI-1:0]  act_word,
   output logic                acc_first,
   output logic                acc_last
);

   import mvau_pkg::*;

   localparam int SF      = calc_sf(MATRIX_W, SIMD);
   localparam int NF      = calc_nf(MATRIX_H, PE);
   localparam int SF_BW   = idx_bw(SF);
   localparam int NF_BW   = idx_bw(NF);
   localparam int ADDR_BW = wmem_addr_bw(SF, NF);

   logic [SIMD*TI-1:0] vec [SF];
   logic [SF_BW-1:0]   beat_cnt;
   logic [SF_BW-1:0]   sf_cnt;
   logic [NF_BW-1:0]   nf_cnt;
   logic [SIMD*TI-1:0] act_s1;
   logic               first_s1;
   logic               last_s1;

   // Beat collection, then nf/sf replay
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         beat_cnt <= '0;
         sf_cnt   <= '0;
         nf_cnt   <= '0;
         in_busy  <= 1'b0;
      end else if (!in_busy) begin
         if (in_valid) begin
            if (beat_cnt == SF_BW'(SF - 1)) begin
               beat_cnt <= '0;
               in_busy  <= 1'b1;
            end else begin
               beat_cnt <= beat_cnt + 1'b1;
            end
         end
      end else if (sf_cnt == SF_BW'(SF - 1)) begin
         sf_cnt <= '0;
         if (nf_cnt == NF_BW'(NF - 1)) begin
            nf_cnt  <= '0;
            in_busy <= 1'b0;  // last address goes out on this edge
         end else begin
            nf_cnt <= nf_cnt + 1'b1;
         end
      end else begin
         sf_cnt <= sf_cnt + 1'b1;
      end
   end

   // Vector store
   always_ff @(posedge clk) begin
      if (in_valid && !in_busy) begin
         vec[beat_cnt] <= in_data;
      end
   end

   // Address stage plus one delay stage to meet the memory read
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wmem_addr <= '0;
         first_s1  <= 1'b0;
         last_s1   <= 1'b0;
         acc_first <= 1'b0;
         acc_last  <= 1'b0;
      end else begin
         if (in_busy) begin
            wmem_addr <= ADDR_BW'(int'(nf_cnt) * SF + int'(sf_cnt));
         end
         first_s1  <= in_busy && (sf_cnt == '0);
         last_s1   <= in_busy && (sf_cnt == SF_BW'(SF - 1));
         acc_first <= first_s1;
         acc_last  <= last_s1;
      end
   end

   // Activation payload, same two stages
   // vec is read only while busy, so a new vector can load behind it
   always_ff @(posedge clk) begin
      act_s1   <= vec[sf_cnt];
      act_word <= act_s1;
   end

   a_no_beat_when_busy : assert property (
      @(posedge clk) disable iff (!rst_n)
      in_valid |-> !in_busy
   ) else $error("input beat while buffer busy");

endmodule

`default_nettype wire

//--- mvau_pe.sv
/* MVAU processing lane
   Owns one weight memory, SIMD-wide signed MAC folded over the synapse fold */

`timescale 1ns/1ps
`default_nettype none

module mvau_pe #(
   parameter int PE_ID    = 0,
   parameter int SIMD     = 4,
   parameter int TI       = 4,
   parameter int TW       = 4,
   parameter int TA       = 16,
   parameter int MATRIX_W = 16,
   parameter int MATRIX_H = 8,
   parameter int PE       = 4
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [mvau_pkg::wmem_addr_bw(
                    mvau_pkg::calc_sf(MATRIX_W, SIMD),
                    mvau_pkg::calc_nf(MATRIX_H, PE))-1:0] wmem_addr,
   input  logic [SIMD*TI-1:0]                act_word,
   input  logic                              acc_first,
   input  logic                              acc_last,
   input  logic                              wload_en,
   input  logic [mvau_pkg::idx_bw(PE)-1:0]   wload_pe,
   input  logic [mvau_pkg::wmem_addr_bw(
                    mvau_pkg::calc_sf(MATRIX_W, SIMD),
                    mvau_pkg::calc_nf(MATRIX_H, PE))-1:0] wload_addr,
   input  logic [SIMD*TW-1:0]                wload_data,
   output logic [TA-1:0]                     acc_out,
   output logic                              acc_valid
);

   import mvau_pkg::*;

   localparam int SF      = calc_sf(MATRIX_W, SIMD);
   localparam int NF      = calc_nf(MATRIX_H, PE);
   localparam int ADDR_BW = wmem_addr_bw(SF, NF);
   localparam int PE_BW   = idx_bw(PE);
   // Adder tree padded to a power of two
   localparam int LVL     = $clog2(SIMD);
   localparam int N2      = 1 << LVL;

   logic                  wload_hit;
   logic [SIMD*TW-1:0]    wmem_data;
   logic signed [TA-1:0]  node [2*N2-1];
   logic signed [TA-1:0]  acc;
   logic signed [TA-1:0]  acc_next;

   // Write decode for this lane
   assign wload_hit = wload_en && (wload_pe == PE_BW'(PE_ID));

   mvau_weight_mem #(
      .SIMD    (SIMD),
      .TW      (TW),
      .DEPTH   (SF * NF),
      .ADDR_BW (ADDR_BW)
   ) i_wmem (
      .clk     (clk),
      .rd_addr (wmem_addr),
      .rd_data (wmem_data),
      .wr_en   (wload_hit),
      .wr_addr (wload_addr),
      .wr_data (wload_data)
   );

   // Leaves, one signed product per SIMD lane
   for (genvar s = 0; s < N2; s++) begin : g_leaf
      if (s < SIMD) begin : g_mul
         logic signed [TI-1:0]    a;
         logic signed [TW-1:0]    w;
         logic signed [TI+TW-1:0] prod;
         assign a    = act_word[s*TI +: TI];
         assign w    = wmem_data[s*TW +: TW];
         assign prod = a * w;
         assign node[N2-1+s] = TA'(prod);  // sign extend or wrap
      end else begin : g_pad
         assign node[N2-1+s] = '0;
      end
   end

   // Inner nodes, heap order, root at node[0]
   for (genvar i = 0; i < N2 - 1; i++) begin : g_add
      assign node[i] = node[2*i+1] + node[2*i+2];
   end

   // First column reloads, later columns add on
   assign acc_next = acc_first ? node[0] : acc + node[0];

   // Running sum, free running between folds
   always_ff @(posedge clk) begin
      acc <= acc_next;
      if (acc_last) begin
         acc_out <= acc_next;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc_valid <= 1'b0;
      end else begin
         acc_valid <= acc_last;
      end
   end

   // Weight writes must not overlap an accumulation in flight
   a_no_load_in_flight : assert property (
      @(posedge clk) disable iff (!rst_n)
      wload_hit |-> !(acc_first || acc_last)
   ) else $error("lane %0d weight write during accumulation", PE_ID);

endmodule

`default_nettype wire

//--- mvau_weight_mem.sv
/* MVAU weight memory
   Register array of SIMD*TW words, registered read, runtime write port */

`timescale 1ns/1ps
`default_nettype none

module mvau_weight_mem #(
   parameter int SIMD    = 4,
   parameter int TW      = 4,
   parameter int DEPTH   = 8,
   parameter int ADDR_BW = 3
) (
   input  logic                 clk,
   input  logic [ADDR_BW-1:0]   rd_addr,
   output logic [SIMD*TW-1:0]   rd_data,
   input  logic                 wr_en,
   input  logic [ADDR_BW-1:0]   wr_addr,
   input  logic [SIMD*TW-1:0]   wr_data
);

   // One word per (nf, sf) pair
   // Lane s of a word sits at bit offset s*TW
   logic [SIMD*TW-1:0] mem [DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read port, one cycle latency
   // Same-address write in the same cycle returns the old word
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

   // Address range checks
   // Depth need not be a power of two, so the top codes are illegal
   a_rd_addr_range : assert property (
      @(posedge clk) rd_addr < DEPTH
   ) else $error("weight mem read address %0d out of range", rd_addr);

   a_wr_addr_range : assert property (
      @(posedge clk) wr_en |-> (wr_addr < DEPTH)
   ) else $error("weight mem write address %0d out of range", wr_addr);

endmodule

`default_nettype wire

//--- mvau_pkg.sv
/* MVAU shared package
   Default array sizes and the fold and width helpers */

`default_nettype none

package mvau_pkg;

   // Default sizes
   localparam int DEF_SIMD     = 4;   // activations per beat
   localparam int DEF_PE       = 4;   // processing lanes
   localparam int DEF_TI       = 4;   // activation bits
   localparam int DEF_TW       = 4;   // weight bits
   localparam int DEF_TA       = 16;  // accumulator bits
   localparam int DEF_MATRIX_W = 16;  // matrix columns
   localparam int DEF_MATRIX_H = 8;   // matrix rows

   // Synapse fold, beats per input vector
   function automatic int calc_sf(input int matrix_w, input int simd);
      return matrix_w / simd;
   endfunction

   // Neuron fold, row groups per vector
   function automatic int calc_nf(input int matrix_h, input int pe);
      return matrix_h / pe;
   endfunction

   // Index width for n items, at least one bit
   function automatic int idx_bw(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

   // Weight memory address width for a depth of sf*nf
   function automatic int wmem_addr_bw(input int sf, input int nf);
      return idx_bw(sf * nf);
   endfunction

endpackage

`default_nettype wire
